/* common/eb_params.svh */
`ifndef EB_PARAMS_SVH
`define EB_PARAMS_SVH

// ********************
// buffer geometry
// ********************
`define EB_ADDRESS_WIDTH 4 // plus one wrap bit in the pointers.
`define EB_DEPTH 16

// ********************
// line-code symbols
// ********************
`define EB_COMMA_SYMBOL 10'h1BC // K28.5 style comma.
`define EB_SKIP_SYMBOL 10'h1A1

// ********************
// flow control
// ********************
`define EB_REMOVE_THRESHOLD 10 // remove skips only above this fill.
`define EB_CREDITS 4 // consumer pool granted at reset.

`endif

/* common/eb_symbol_pkg.sv */
package eb_symbol_pkg;

    // ********************
    // symbol classes
    // ********************

    // classification of one 10-bit received code.
    typedef enum logic [1:0] {
        sym_data,
        sym_comma,
        sym_skip
    } symbol_class_e;

endpackage

/* common/eb_ctrl_pkg.sv */
`include "eb_params.svh"

package eb_ctrl_pkg;

    // ********************
    // skip removal states
    // ********************
    typedef enum logic [1:0] {
        waiting_for_comma,
        comma_detected,
        skip_and_stall // second removed cycle.
    } skip_state_e;

    typedef logic [`EB_ADDRESS_WIDTH:0] pointer_t; // msb is the wrap bit.

endpackage

/* skip_removal/skip_fsm.sv */
`include "eb_params.svh"

module skip_fsm (
    input  logic                         recovered_clock,
    input  logic                         recovered_reset,
    input  logic [9:0]                   data_in,
    input  logic [`EB_ADDRESS_WIDTH-1:0] fill_level,
    output logic                         write_enable,
    output logic                         skip_removed
);

    import eb_symbol_pkg::*;
    import eb_ctrl_pkg::*;

    symbol_class_e symbol_class;
    skip_state_e   current_state;
    skip_state_e   next_state;
    logic          above_threshold;

    always_comb begin
        if (data_in == `EB_COMMA_SYMBOL) begin
            symbol_class = sym_comma;
        end else if (data_in == `EB_SKIP_SYMBOL) begin
            symbol_class = sym_skip;
        end else begin
            symbol_class = sym_data;
        end
    end

    assign above_threshold = fill_level > `EB_REMOVE_THRESHOLD;

    always_ff @(posedge recovered_clock or negedge recovered_reset) begin
        if (!recovered_reset) begin
            current_state <= waiting_for_comma;
        end else begin
            current_state <= next_state;
        end
    end

    // ********************
    // removal decision
    // ********************
    always_comb begin
        next_state   = waiting_for_comma;
        skip_removed = 1'b0;
        case (current_state)
            waiting_for_comma: begin
                if (symbol_class == sym_comma) begin
                    next_state = comma_detected;
                end
            end
            comma_detected: begin
                if (symbol_class == sym_skip && above_threshold) begin
                    next_state   = skip_and_stall;
                    skip_removed = 1'b1; // drop the skip itself.
                end
            end
            skip_and_stall: begin
                skip_removed = 1'b1; // drop the stall cycle.
            end
            default: next_state = waiting_for_comma;
        endcase
    end

    assign write_enable = !skip_removed;

endmodule

/* skip_removal/fill_counter.sv */
`include "eb_params.svh"

module fill_counter (
    input  logic                         recovered_clock,
    input  logic                         recovered_reset,
    input  logic                         write_enable,
    input  logic                         read_enable,
    output eb_ctrl_pkg::pointer_t        write_pointer,
    output eb_ctrl_pkg::pointer_t        read_pointer,
    output logic [`EB_ADDRESS_WIDTH-1:0] fill_level,
    output logic                         empty,
    output logic                         overflow
);

    import eb_ctrl_pkg::*;

    pointer_t pointer_difference;
    logic     full_next;
    logic     full;
    logic     prev_full;

    // ********************
    // pointers
    // ********************
    always_ff @(posedge recovered_clock or negedge recovered_reset) begin
        if (!recovered_reset) begin
            write_pointer <= '0;
        end else if (write_enable) begin
            write_pointer <= write_pointer + 1'b1; // keeps going when lapped.
        end
    end

    always_ff @(posedge recovered_clock or negedge recovered_reset) begin
        if (!recovered_reset) begin
            read_pointer <= '0;
        end else if (read_enable) begin
            read_pointer <= read_pointer + 1'b1;
        end
    end

    assign empty = write_pointer == read_pointer;

    assign pointer_difference = write_pointer - read_pointer;

    // same slot, opposite wrap bit.
    assign full_next =
        (write_pointer[`EB_ADDRESS_WIDTH] != read_pointer[`EB_ADDRESS_WIDTH]) &&
        (write_pointer[`EB_ADDRESS_WIDTH-1:0] == read_pointer[`EB_ADDRESS_WIDTH-1:0]);

    // ********************
    // level and overflow
    // ********************
    always_ff @(posedge recovered_clock or negedge recovered_reset) begin
        if (!recovered_reset) begin
            fill_level <= '0;
            full       <= 1'b0;
            prev_full  <= 1'b0;
            overflow   <= 1'b0;
        end else begin
            fill_level <= pointer_difference[`EB_ADDRESS_WIDTH-1:0]; // modulo depth.
            full       <= full_next;
            prev_full  <= full;
            // a write past full wraps the level back to one.
            overflow   <= prev_full && (fill_level == 1);
        end
    end

endmodule

/* hw/symbol_ram.sv */
`include "eb_params.svh"

module symbol_ram (
    input  logic                         recovered_clock,
    input  logic                         write_enable,
    input  logic [`EB_ADDRESS_WIDTH-1:0] write_address,
    input  logic [9:0]                   data_in,
    input  logic [`EB_ADDRESS_WIDTH-1:0] read_address,
    output logic [9:0]                   read_data
);

    logic [9:0] memory [`EB_DEPTH];

    always_ff @(posedge recovered_clock) begin
        if (write_enable) begin
            memory[write_address] <= data_in;
        end
    end

    assign read_data = memory[read_address]; // async read.

endmodule

/* hw/credit_sender.sv */
`include "eb_params.svh"

module credit_sender (
    input  logic       recovered_clock,
    input  logic       recovered_reset,
    input  logic       empty,
    input  logic [9:0] read_data,
    input  logic       credit_return,
    output logic       read_enable,
    output logic [9:0] data_out,
    output logic       data_valid
);

    localparam int CREDIT_WIDTH = $clog2(`EB_CREDITS + 1);

    logic [CREDIT_WIDTH-1:0] credit_count;
    logic                    credit_available;

    assign credit_available = credit_count != '0;
    assign read_enable      = !empty && credit_available;

    // ********************
    // credit counter
    // ********************
    always_ff @(posedge recovered_clock or negedge recovered_reset) begin
        if (!recovered_reset) begin
            credit_count <= CREDIT_WIDTH'(`EB_CREDITS);
        end else begin
            case ({read_enable, credit_return})
                2'b10: credit_count <= credit_count - 1'b1;
                2'b01: credit_count <= credit_count + 1'b1;
                default: credit_count <= credit_count; // pop and return cancel.
            endcase
        end
    end

    // ********************
    // output stage
    // ********************
    always_ff @(posedge recovered_clock or negedge recovered_reset) begin
        if (!recovered_reset) begin
            data_valid <= 1'b0;
        end else begin
            data_valid <= read_enable;
        end
    end

    always_ff @(posedge recovered_clock) begin
        if (read_enable) begin
            data_out <= read_data;
        end
    end

endmodule

/* hw/elastic_buffer_top.sv */
`include "eb_params.svh"

module elastic_buffer_top (
    input  logic                         recovered_clock,
    input  logic                         recovered_reset,
    input  logic [9:0]                   data_in,
    input  logic                         credit_return,
    output logic [9:0]                   data_out,
    output logic                         data_valid,
    output logic                         skip_removed,
    output logic                         overflow,
    output logic [`EB_ADDRESS_WIDTH-1:0] fill_level
);

    import eb_ctrl_pkg::*;

    pointer_t   write_pointer;
    pointer_t   read_pointer;
    logic       write_enable;
    logic       read_enable;
    logic       empty;
    logic [9:0] read_data;

    // ********************
    // receive side
    // ********************
    skip_fsm i_skip_fsm (
        .recovered_clock (recovered_clock),
        .recovered_reset (recovered_reset),
        .data_in         (data_in),
        .fill_level      (fill_level),
        .write_enable    (write_enable),
        .skip_removed    (skip_removed)
    );

    fill_counter i_fill_counter (
        .recovered_clock (recovered_clock),
        .recovered_reset (recovered_reset),
        .write_enable    (write_enable),
        .read_enable     (read_enable),
        .write_pointer   (write_pointer),
        .read_pointer    (read_pointer),
        .fill_level      (fill_level),
        .empty           (empty),
        .overflow        (overflow)
    );

    symbol_ram i_symbol_ram (
        .recovered_clock (recovered_clock),
        .write_enable    (write_enable),
        .write_address   (write_pointer[`EB_ADDRESS_WIDTH-1:0]), // wrap bit dropped.
        .data_in         (data_in),
        .read_address    (read_pointer[`EB_ADDRESS_WIDTH-1:0]),
        .read_data       (read_data)
    );

    // ********************
    // send side
    // ********************
    credit_sender i_credit_sender (
        .recovered_clock (recovered_clock),
        .recovered_reset (recovered_reset),
        .empty           (empty),
        .read_data       (read_data),
        .credit_return   (credit_return),
        .read_enable     (read_enable),
        .data_out        (data_out),
        .data_valid      (data_valid)
    );

endmodule

/* test/tb_clock_gen.sv */
module tb_clock_gen (
    output logic recovered_clock,
    output logic recovered_reset
);

    initial begin
        recovered_clock = 1'b0;
        forever begin
            #2 recovered_clock = ~recovered_clock; // period of 4.
        end
    end

    initial begin
        recovered_reset = 1'b0;
        repeat (4) @(posedge recovered_clock);
        recovered_reset <= 1'b1; // released on the 4th edge.
    end

endmodule

/* test/elastic_buffer_sva.sv */
`include "eb_params.svh"

module elastic_buffer_sva (
    input logic                         recovered_clock,
    input logic                         recovered_reset,
    input logic [9:0]                   data_in,
    input logic                         credit_return,
    input logic [9:0]                   data_out,
    input logic                         data_valid,
    input logic                         skip_removed,
    input logic                         overflow,
    input logic [`EB_ADDRESS_WIDTH-1:0] fill_level
);

    import eb_symbol_pkg::*;

    int         failure_count = 0;
    logic       comma_seen;
    logic       overflow_seen;
    logic       have_last;
    logic [7:0] last_payload;
    int         outstanding;
    int         skips_written;
    int         skips_sent;

    function automatic symbol_class_e classify(input logic [9:0] code);
        if (code == `EB_COMMA_SYMBOL) begin
            return sym_comma;
        end
        if (code == `EB_SKIP_SYMBOL) begin
            return sym_skip;
        end
        return sym_data;
    endfunction

    // ********************
    // reference state
    // ********************
    always_ff @(posedge recovered_clock or negedge recovered_reset) begin
        if (!recovered_reset) begin
            comma_seen    <= 1'b0;
            overflow_seen <= 1'b0;
            have_last     <= 1'b0;
            last_payload  <= '0;
            outstanding   <= 0;
            skips_written <= 0;
            skips_sent    <= 0;
        end else begin
            comma_seen    <= comma_seen || (classify(data_in) == sym_comma);
            overflow_seen <= overflow_seen || overflow;
            outstanding   <= outstanding + int'(data_valid) - int'(credit_return);
            if (data_valid && classify(data_out) == sym_data) begin
                have_last    <= 1'b1;
                last_payload <= data_out[7:0];
            end
            if (classify(data_in) == sym_skip && !skip_removed) begin
                skips_written <= skips_written + 1; // skip actually stored.
            end
            if (data_valid && classify(data_out) == sym_skip) begin
                skips_sent <= skips_sent + 1;
            end
        end
    end

    // ********************
    // assertions
    // ********************
    idle_before_comma: assert property (@(posedge recovered_clock) disable iff (!recovered_reset)
        !comma_seen |-> !data_valid && !overflow && !skip_removed)
        else begin
            failure_count++;
            $error("error before first comma data_valid 0x%0h overflow 0x%0h skip_removed 0x%0h",
                data_valid, overflow, skip_removed);
        end

    skip_dropped: assert property (@(posedge recovered_clock) disable iff (!recovered_reset)
        ($past(data_in) == `EB_COMMA_SYMBOL && data_in == `EB_SKIP_SYMBOL &&
         fill_level > `EB_REMOVE_THRESHOLD) |-> skip_removed)
        else begin
            failure_count++;
            $error("error skip_removed 0x%0h fill_level 0x%0h", skip_removed, fill_level);
        end

    stall_dropped: assert property (@(posedge recovered_clock) disable iff (!recovered_reset)
        ($past(data_in) == `EB_COMMA_SYMBOL && data_in == `EB_SKIP_SYMBOL &&
         fill_level > `EB_REMOVE_THRESHOLD) |=> skip_removed)
        else begin
            failure_count++;
            $error("error skip_removed 0x%0h in stall cycle", skip_removed);
        end

    skip_kept: assert property (@(posedge recovered_clock) disable iff (!recovered_reset)
        ($past(data_in) == `EB_COMMA_SYMBOL && data_in == `EB_SKIP_SYMBOL &&
         fill_level <= `EB_REMOVE_THRESHOLD) |-> !skip_removed)
        else begin
            failure_count++;
            $error("error skip_removed 0x%0h fill_level 0x%0h", skip_removed, fill_level);
        end

    credit_bound: assert property (@(posedge recovered_clock) disable iff (!recovered_reset)
        outstanding <= `EB_CREDITS && (data_valid -> outstanding < `EB_CREDITS))
        else begin
            failure_count++;
            $error("error outstanding 0x%0h data_valid 0x%0h", outstanding, data_valid);
        end

    payload_step: assert property (@(posedge recovered_clock) disable iff (!recovered_reset)
        (data_valid && classify(data_out) == sym_data && have_last && !overflow_seen &&
         !overflow) |-> data_out[7:0] == 8'(last_payload + 8'd1))
        else begin
            failure_count++;
            $error("error data_out payload 0x%0h expected 0x%0h",
                data_out[7:0], 8'(last_payload + 8'd1));
        end

    removed_skip_absent: assert property (@(posedge recovered_clock) disable iff (!recovered_reset)
        (data_valid && classify(data_out) == sym_skip && !overflow_seen) |->
        skips_sent < skips_written)
        else begin
            failure_count++;
            $error("a removed skip symbol appeared on data_out");
        end

    overflow_after_lap: assert property (@(posedge recovered_clock) disable iff (!recovered_reset)
        overflow |-> $past(fill_level) == 1)
        else begin
            failure_count++;
            $error("error overflow 0x%0h previous fill_level 0x%0h", overflow, $past(fill_level));
        end

    overflow_single: assert property (@(posedge recovered_clock) disable iff (!recovered_reset)
        overflow |=> !overflow)
        else begin
            failure_count++;
            $error("error overflow 0x%0h held longer than one cycle", overflow);
        end

    overflow_reached: cover property (@(posedge recovered_clock) disable iff (!recovered_reset)
        overflow);

    removal_reached: cover property (@(posedge recovered_clock) disable iff (!recovered_reset)
        skip_removed);

endmodule

bind elastic_buffer_top elastic_buffer_sva i_elastic_buffer_sva (
    .recovered_clock (recovered_clock),
    .recovered_reset (recovered_reset),
    .data_in         (data_in),
    .credit_return   (credit_return),
    .data_out        (data_out),
    .data_valid      (data_valid),
    .skip_removed    (skip_removed),
    .overflow        (overflow),
    .fill_level      (fill_level)
);

/* test/elastic_buffer_tb.sv */
`include "eb_params.svh"

module elastic_buffer_tb;

    logic                         recovered_clock;
    logic                         recovered_reset;
    logic [9:0]                   data_in;
    logic                         credit_return = 1'b0;
    logic [9:0]                   data_out;
    logic                         data_valid;
    logic                         skip_removed;
    logic                         overflow;
    logic [`EB_ADDRESS_WIDTH-1:0] fill_level;

    integer     seed = 32'h2adb7da1;
    logic       credits_enabled;
    int         pending_credits = 0;
    int         stream_slot;
    logic [7:0] payload;
    int         wait_cycles;

    tb_clock_gen i_tb_clock_gen (
        .recovered_clock (recovered_clock),
        .recovered_reset (recovered_reset)
    );

    elastic_buffer_top i_elastic_buffer_top (
        .recovered_clock (recovered_clock),
        .recovered_reset (recovered_reset),
        .data_in         (data_in),
        .credit_return   (credit_return),
        .data_out        (data_out),
        .data_valid      (data_valid),
        .skip_removed    (skip_removed),
        .overflow        (overflow),
        .fill_level      (fill_level)
    );

    // ********************
    // consumer model
    // ********************
    always @(posedge recovered_clock) begin
        if (!recovered_reset) begin
            pending_credits = 0;
            credit_return <= 1'b0;
        end else begin
            if (data_valid) begin
                pending_credits++;
            end
            // returns skip about one cycle in eight.
            if (credits_enabled && pending_credits > 0 && ($random(seed) & 7) != 0) begin
                credit_return <= 1'b1;
                pending_credits--;
            end else begin
                credit_return <= 1'b0;
            end
        end
    end

    always @(posedge recovered_clock) begin
        if (i_elastic_buffer_top.i_elastic_buffer_sva.failure_count != 0) begin
            $display("checker assertion failed, stopping the run");
            $display("sim failed");
            $fatal(1, "checker reported a failure");
        end
    end

    task automatic stop_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("sim failed");
        $fatal(1, "timeout");
    endtask

    // comma, skip, skip, then five data symbols.
    task automatic send_next_symbol(input bit with_controls);
        @(posedge recovered_clock);
        if (with_controls && stream_slot == 0) begin
            data_in <= `EB_COMMA_SYMBOL;
        end else if (with_controls && stream_slot < 3) begin
            data_in <= `EB_SKIP_SYMBOL;
        end else begin
            data_in <= {2'b10, payload};
            payload = payload + 8'd1;
        end
        stream_slot = (stream_slot + 1) % 8;
    endtask

    task automatic send_stream(input int count, input bit with_controls);
        for (int i = 0; i < count; i++) begin
            send_next_symbol(with_controls);
        end
    endtask

    initial begin
        data_in         = `EB_COMMA_SYMBOL; // first stored symbol is a comma.
        credits_enabled = 1'b1;
        stream_slot     = 1;
        payload         = 8'd0;
        wait_cycles     = 0;
        while (recovered_reset !== 1'b1) begin
            @(posedge recovered_clock);
            wait_cycles++;
            if (wait_cycles > 20) begin
                stop_on_timeout("reset release");
            end
        end

        // ********************
        // steady traffic
        // ********************
        send_stream(200, 1'b1);

        // hold credits until above the threshold.
        credits_enabled <= 1'b0;
        wait_cycles = 0;
        while (fill_level < 12) begin
            send_next_symbol(1'b1);
            wait_cycles++;
            if (wait_cycles > 100) begin
                stop_on_timeout("fill level above threshold");
            end
        end
        credits_enabled <= 1'b1;
        send_stream(120, 1'b1);

        // ********************
        // lap the buffer
        // ********************
        credits_enabled <= 1'b0;
        wait_cycles = 0;
        while (!overflow) begin
            send_next_symbol(1'b0);
            wait_cycles++;
            if (wait_cycles > 100) begin
                stop_on_timeout("overflow pulse");
            end
        end
        send_stream(4, 1'b0);

        if (i_elastic_buffer_top.i_elastic_buffer_sva.failure_count == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("sim failed");
            $fatal(1, "checker reported a failure");
        end
    end

endmodule

/* all.f */
+incdir+common
common/eb_symbol_pkg.sv
common/eb_ctrl_pkg.sv
skip_removal/skip_fsm.sv
skip_removal/fill_counter.sv
hw/symbol_ram.sv
hw/credit_sender.sv
hw/elastic_buffer_top.sv
test/tb_clock_gen.sv
test/elastic_buffer_sva.sv
test/elastic_buffer_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --assert --timing -j 0
TOP       ?= elastic_buffer_tb
FILELIST  ?= all.f
RUN_FLAGS ?= +verilator+error+limit+100
BUILD_DIR ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@output="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1)"; \
	echo "$$output"; \
	echo "$$output" | grep -qx "sim passed"

lint:
	$(VERILATOR) --lint-only --assert --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
